//--- mult_pkg.sv
package mult_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int OPERAND_W  = 5;
    localparam int PRODUCT_W  = 2 * OPERAND_W;
    localparam int DIGIT_W    = 4;
    localparam int NUM_DIGITS = 4;
    localparam int NUM_STAGES = 3;   // thousands, hundreds, tens

    typedef logic [OPERAND_W-1:0]  operand_t;
    typedef logic [PRODUCT_W-1:0]  product_t;   // product or remainder
    typedef logic [DIGIT_W-1:0]    digit_t;
    typedef logic [7:0]            seg_t;       // active low, bit 0 is dp
    typedef logic [NUM_DIGITS-1:0] anode_t;     // active low
    typedef logic [1:0]            scan_pos_t;

    // --------------------------------------------------
    // digit and segment codes
    // --------------------------------------------------
    localparam digit_t DIGIT_BLANK = digit_t'(15);

    // patterns for 0 through 9, dp stays off
    localparam seg_t SEG_TABLE [10] = '{
        8'h03, 8'h9F, 8'h25, 8'h0D, 8'h99,
        8'h49, 8'h41, 8'h1F, 8'h01, 8'h09
    };

    localparam seg_t SEG_BLANK = 8'hFF;   // all segments dark

    // --------------------------------------------------
    // controller
    // --------------------------------------------------
    typedef enum logic {
        ST_WAIT  = 1'b0,
        ST_SHIFT = 1'b1
    } mult_state_t;

    typedef struct packed {
        logic load_operands;   // operand regs follow the inputs
        logic clear_acc;
        logic shift;           // multiplicand left, multiplier right
        logic acc_en;
    } mult_ctrl_t;

    // --------------------------------------------------
    // digit chain
    // --------------------------------------------------
    typedef struct packed {
        product_t rem;
        logic     lead_blank;  // all higher digits were blank
    } decade_t;

endpackage

//--- shift_add_fsm.sv
`timescale 1ns/100ps

module shift_add_fsm (
    input  logic                clockin,
    input  logic                clk,
    input  logic                start,
    input  logic                multiplier_zero,
    output mult_pkg::mult_ctrl_t ctrl
);

    import mult_pkg::*;

    mult_state_t state_q;
    mult_state_t state_d;

    // --------------------------------------------------
    // state register
    // --------------------------------------------------
    always_ff @(posedge clockin or posedge clk) begin
        if (clk) begin
            state_q <= ST_WAIT;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------
    // next state and outputs
    // --------------------------------------------------
    always_comb begin
        ctrl    = '0;
        state_d = state_q;

        case (state_q)
            ST_WAIT: begin
                // operands track the switches while idle
                ctrl.load_operands = 1'b1;
                if (start) begin
                    ctrl.clear_acc = 1'b1;   // fresh product
                    state_d        = ST_SHIFT;
                end
            end

            ST_SHIFT: begin
                ctrl.shift  = 1'b1;
                ctrl.acc_en = 1'b1;   // adds zero once multiplier is empty
                if (multiplier_zero) begin
                    state_d = ST_WAIT;
                end
            end

            default: begin
                state_d = ST_WAIT;
            end
        endcase
    end

endmodule

//--- shift_add_datapath.sv
`timescale 1ns/100ps

module shift_add_datapath (
    input  logic                 clockin,
    input  logic                 clk,
    input  mult_pkg::operand_t   operand_a,
    input  mult_pkg::operand_t   operand_b,
    input  mult_pkg::mult_ctrl_t ctrl,
    output logic                 multiplier_zero,
    output mult_pkg::product_t   product
);

    import mult_pkg::*;

    product_t mcand_q;   // multiplicand, widened to product width
    operand_t mplier_q;  // multiplier
    product_t acc_q;     // running product
    product_t addend;

    // --------------------------------------------------
    // multiplicand, shifts left
    // --------------------------------------------------
    always_ff @(posedge clockin or posedge clk) begin
        if (clk) begin
            mcand_q <= '0;
        end else if (ctrl.load_operands) begin
            mcand_q <= {{(PRODUCT_W - OPERAND_W){1'b0}}, operand_a};
        end else if (ctrl.shift) begin
            mcand_q <= {mcand_q[PRODUCT_W-2:0], 1'b0};
        end
    end

    // --------------------------------------------------
    // multiplier, shifts right
    // --------------------------------------------------
    always_ff @(posedge clockin or posedge clk) begin
        if (clk) begin
            mplier_q <= '0;
        end else if (ctrl.load_operands) begin
            mplier_q <= operand_b;
        end else if (ctrl.shift) begin
            mplier_q <= {1'b0, mplier_q[OPERAND_W-1:1]};
        end
    end

    assign multiplier_zero = (mplier_q == '0);

    // partial product for the current multiplier bit
    assign addend = mplier_q[0] ? mcand_q : '0;

    // --------------------------------------------------
    // accumulator
    // --------------------------------------------------
    // 31 x 31 = 961 fits, no carry needed
    always_ff @(posedge clockin or posedge clk) begin
        if (clk) begin
            acc_q <= '0;
        end else if (ctrl.clear_acc) begin
            acc_q <= '0;
        end else if (ctrl.acc_en) begin
            acc_q <= acc_q + addend;
        end
    end

    assign product = acc_q;   // holds between runs

endmodule

//--- decade_stage.sv
`timescale 1ns/100ps

module decade_stage #(
    parameter int weight = 1000   // place value of this digit
) (
    input  mult_pkg::decade_t upper,
    output mult_pkg::decade_t lower,
    output mult_pkg::digit_t  digit
);

    import mult_pkg::*;

    digit_t digit_val;
    logic   is_blank;

    // largest k in 0..9 with k * weight <= remainder
    always_comb begin
        digit_val = '0;
        for (int k = 1; k <= 9; k++) begin
            if (int'(upper.rem) >= k * weight) begin
                digit_val = digit_t'(k);   // last hit wins
            end
        end
    end

    // zero digit stays dark while nothing above it lit
    assign is_blank = upper.lead_blank && (digit_val == '0);

    assign digit            = is_blank ? DIGIT_BLANK : digit_val;
    assign lower.rem        = upper.rem - product_t'(int'(digit_val) * weight);
    assign lower.lead_blank = is_blank;

endmodule

//--- digit_scanner.sv
`timescale 1ns/100ps

module digit_scanner #(
    parameter int scan_div_bits = 16
) (
    input  logic                                     clockin,
    input  logic                                     clk,
    input  mult_pkg::digit_t [mult_pkg::NUM_STAGES-1:0] digits,
    input  mult_pkg::decade_t                        ones,
    output mult_pkg::seg_t                           sseg,
    output mult_pkg::anode_t                         anode
);

    import mult_pkg::*;

    logic [scan_div_bits-1:0] tick_cnt;
    logic                     tick;       // one cycle per scan step
    scan_pos_t                scan_pos;
    digit_t                   cur_digit;

    // --------------------------------------------------
    // scan timing
    // --------------------------------------------------
    assign tick = &tick_cnt;   // about to wrap

    always_ff @(posedge clockin or posedge clk) begin
        if (clk) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clockin or posedge clk) begin
        if (clk) begin
            scan_pos <= '0;
        end else if (tick) begin
            scan_pos <= scan_pos + 1'b1;   // wraps 3 -> 0
        end
    end

    // --------------------------------------------------
    // digit select
    // --------------------------------------------------
    // position 0 is thousands, last position is ones
    always_comb begin
        if (scan_pos == scan_pos_t'(NUM_DIGITS - 1)) begin
            // final remainder is below ten, never blanked
            cur_digit = ones.rem[DIGIT_W-1:0];
        end else begin
            cur_digit = digits[scan_pos];
        end
    end

    // --------------------------------------------------
    // segment decode
    // --------------------------------------------------
    always_comb begin
        if (cur_digit <= digit_t'(9)) begin
            sseg = SEG_TABLE[cur_digit];
        end else begin
            sseg = SEG_BLANK;   // DIGIT_BLANK and unused codes
        end
    end

    // one low anode per position, 1110 first
    assign anode = ~(anode_t'(1) << scan_pos);

endmodule

//--- mult_display_top.sv
`timescale 1ns/100ps

module mult_display_top #(
    parameter int scan_div_bits = 16
) (
    input  logic               clockin,
    input  logic               clk,
    input  mult_pkg::operand_t operand_a,
    input  mult_pkg::operand_t operand_b,
    input  logic               start,
    output mult_pkg::seg_t     sseg,
    output mult_pkg::anode_t   anode
);

    import mult_pkg::*;

    mult_ctrl_t                ctrl;
    logic                      multiplier_zero;
    product_t                  product;
    decade_t                   chain [NUM_STAGES+1];   // remainder between stages
    digit_t [NUM_STAGES-1:0]   digits;

    // --------------------------------------------------
    // shift-and-add multiplier
    // --------------------------------------------------
    shift_add_fsm u_fsm (
        .clockin         (clockin),
        .clk             (clk),
        .start           (start),
        .multiplier_zero (multiplier_zero),
        .ctrl            (ctrl)
    );

    shift_add_datapath u_datapath (
        .clockin         (clockin),
        .clk             (clk),
        .operand_a       (operand_a),
        .operand_b       (operand_b),
        .ctrl            (ctrl),
        .multiplier_zero (multiplier_zero),
        .product         (product)
    );

    // --------------------------------------------------
    // binary to decimal, thousands first
    // --------------------------------------------------
    assign chain[0] = '{rem: product, lead_blank: 1'b1};

    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_decade
        decade_stage #(
            .weight (10 ** (NUM_STAGES - i))   // 1000, 100, 10
        ) u_stage (
            .upper (chain[i]),
            .lower (chain[i+1]),
            .digit (digits[i])
        );
    end

    digit_scanner #(
        .scan_div_bits (scan_div_bits)
    ) u_scanner (
        .clockin (clockin),
        .clk     (clk),
        .digits  (digits),
        .ones    (chain[NUM_STAGES]),
        .sseg    (sseg),
        .anode   (anode)
    );

endmodule

//--- mult_display_properties.sv
`timescale 1ns/100ps

module mult_display_properties (
    input  logic                 clockin,
    input  logic                 clk,
    input  mult_pkg::anode_t     anode,
    input  mult_pkg::product_t   product,
    input  mult_pkg::mult_ctrl_t ctrl
);

    import mult_pkg::*;

    localparam product_t MAX_PRODUCT     = product_t'(961);   // 31 x 31
    localparam int       MAX_BUSY_CYCLES = 7;

    int assert_fails = 0;

    // --------------------------------------------------
    // display and multiplier properties
    // --------------------------------------------------
    one_anode_low: assert property (
        @(posedge clockin) disable iff (clk) $onehot(~anode)
    ) else begin
        assert_fails++;
        $error("anode pattern %b does not enable exactly one digit", anode);
    end

    product_in_range: assert property (
        @(posedge clockin) disable iff (clk) product <= MAX_PRODUCT
    ) else begin
        assert_fails++;
        $error("product %0d above 961", product);
    end

    // load_operands is high only in the idle state
    back_to_wait: assert property (
        @(posedge clockin) disable iff (clk)
        $fell(ctrl.load_operands) |-> ##[1:MAX_BUSY_CYCLES] ctrl.load_operands
    ) else begin
        assert_fails++;
        $error("controller stayed in the shift state too long");
    end

endmodule

bind mult_display_top mult_display_properties u_props (
    .clockin (clockin),
    .clk     (clk),
    .anode   (anode),
    .product (product),
    .ctrl    (ctrl)
);

//--- tb_mult_display.sv
`timescale 1ns/100ps

module tb_mult_display;

    import mult_pkg::*;

    localparam int SCAN_DIV_BITS  = 2;
    localparam int SCAN_CYCLES    = NUM_DIGITS * (2 ** SCAN_DIV_BITS);   // one full sweep
    localparam int RESET_CYCLES   = 16;
    localparam int MULT_WAIT      = 10;
    localparam int OP_COUNT       = 40;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + OP_COUNT * (MULT_WAIT + 20) + 200;

    logic     clockin;
    logic     clk;
    operand_t operand_a;
    operand_t operand_b;
    logic     start;
    seg_t     sseg;
    anode_t   anode;

    int   seed;
    int   cycle_cnt;
    seg_t shown [NUM_DIGITS];   // captured patterns with thousands at index 0

    mult_display_top #(
        .scan_div_bits (SCAN_DIV_BITS)
    ) DUT (
        .clockin   (clockin),
        .clk       (clk),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .start     (start),
        .sseg      (sseg),
        .anode     (anode)
    );

    always #2 clockin = ~clockin;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic wait_drive_slot();
        @(posedge clockin);
        #1;
    endtask

    // active-low patterns for 0..9 and blank for other codes
    function automatic seg_t digit_pattern(input int d);
        case (d)
            0:       return 8'h03;
            1:       return 8'h9F;
            2:       return 8'h25;
            3:       return 8'h0D;
            4:       return 8'h99;
            5:       return 8'h49;
            6:       return 8'h41;
            7:       return 8'h1F;
            8:       return 8'h01;
            9:       return 8'h09;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic seg_t expected_pattern(input int value, input int pos);
        int place;
        place = 10 ** (NUM_DIGITS - 1 - pos);
        if (pos < NUM_DIGITS - 1 && value < place) begin
            return 8'hFF;   // leading zero
        end
        return digit_pattern((value / place) % 10);
    endfunction

    function automatic int anode_position(input anode_t a);
        case (a)
            4'b1110: return 0;
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1;
        endcase
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_seg(input string test_name, input seg_t expected, input seg_t actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", test_name, expected, actual);
            $display("Test failed");
            $fatal(1, "segment mismatch");
        end
    endtask

    task automatic check_anode(input string test_name, input anode_t expected,
                               input anode_t actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %b, actual %b", test_name, expected, actual);
            $display("Test failed");
            $fatal(1, "anode mismatch");
        end
    endtask

    // --------------------------------------------------
    // stimulus and capture
    // --------------------------------------------------
    task automatic multiply(input operand_t a, input operand_t b);
        wait_drive_slot();
        operand_a = a;
        operand_b = b;
        start     = 1'b1;
        wait_drive_slot();
        start = 1'b0;
        repeat (MULT_WAIT) @(posedge clockin);
    endtask

    task automatic read_display(input string test_name);
        int                    pos;
        logic [NUM_DIGITS-1:0] seen;
        seen = '0;
        repeat (SCAN_CYCLES) begin
            @(negedge clockin);   // outputs settled mid-cycle
            pos = anode_position(anode);
            if (pos < 0) begin
                $display("%s: anode pattern %b does not enable exactly one digit",
                         test_name, anode);
                $display("Test failed");
                $fatal(1, "bad anode pattern");
            end
            shown[pos] = sseg;
            seen[pos]  = 1'b1;
        end
        if (seen != '1) begin
            $display("%s: not every digit position was scanned in one sweep", test_name);
            $display("Test failed");
            $fatal(1, "incomplete scan");
        end
    endtask

    task automatic check_display(input string test_name, input int value);
        read_display(test_name);
        for (int pos = 0; pos < NUM_DIGITS; pos++) begin
            check_seg(test_name, expected_pattern(value, pos), shown[pos]);
        end
    endtask

    task automatic run_product(input string test_name, input operand_t a, input operand_t b,
                               input int expected);
        multiply(a, b);
        check_display(test_name, expected);
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_reset_display();
        anode_t order [NUM_DIGITS];
        int     pos;
        order = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};
        for (int n = 0; n < SCAN_CYCLES; n++) begin
            @(negedge clockin);
            // position steps every 2**SCAN_DIV_BITS cycles from reset
            pos = (n / (2 ** SCAN_DIV_BITS)) % NUM_DIGITS;
            check_anode("reset_display", order[pos], anode);
        end
        check_display("reset_display", 0);
    endtask

    task automatic test_directed_products();
        run_product("mul_5x7", 5, 7, 35);
        run_product("mul_31x31", 31, 31, 961);
        run_product("mul_0x19", 0, 19, 0);
        run_product("mul_19x0", 19, 0, 0);
        run_product("mul_1x1", 1, 1, 1);
        run_product("mul_10x10", 10, 10, 100);
    endtask

    task automatic test_random_products();
        operand_t a;
        operand_t b;
        seed = 16;
        for (int i = 0; i < 30; i++) begin
            a = operand_t'($random(seed));
            b = operand_t'($random(seed));
            run_product($sformatf("random_%0d", i), a, b, int'(a) * int'(b));
        end
    endtask

    task automatic test_operands_ignored();
        wait_drive_slot();
        operand_a = 13;
        operand_b = 21;
        start     = 1'b1;
        wait_drive_slot();
        start     = 1'b0;
        operand_a = 31;   // machine already shifting
        operand_b = 31;
        repeat (MULT_WAIT) @(posedge clockin);
        check_display("operands_ignored", 273);
    endtask

    task automatic test_held_start();
        wait_drive_slot();
        operand_a = 23;
        operand_b = 11;
        start     = 1'b1;
        repeat (20) wait_drive_slot();
        start = 1'b0;
        repeat (MULT_WAIT) @(posedge clockin);
        check_display("held_start", 253);
        run_product("held_start_next", 6, 29, 174);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        clockin   = 1'b0;
        clk       = 1'b1;
        start     = 1'b0;
        operand_a = '0;
        operand_b = '0;
        seed      = 16;
        repeat (RESET_CYCLES) @(posedge clockin);
        #1;
        clk = 1'b0;

        test_reset_display();
        test_directed_products();
        test_random_products();
        test_operands_ignored();
        test_held_start();

        if (DUT.u_props.assert_fails != 0) begin
            $display("%0d assertion failures during the run", DUT.u_props.assert_fails);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clockin);
            cycle_cnt++;
        end
        $display("run timed out after %0d cycles", cycle_cnt);
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

//--- src.f
mult_pkg.sv
shift_add_fsm.sv
shift_add_datapath.sv
decade_stage.sv
digit_scanner.sv
mult_display_top.sv
mult_display_properties.sv
tb_mult_display.sv

//--- Bender.yml
package:
  name: mult_display

sources:
  - files:
      - mult_pkg.sv
      - shift_add_fsm.sv
      - shift_add_datapath.sv
      - decade_stage.sv
      - digit_scanner.sv
      - mult_display_top.sv
  - target: test
    files:
      - mult_display_properties.sv
      - tb_mult_display.sv
